/* pipeCtrl_settings.svh */
//==========================================================================
// Pipeline control settings
// Widths of the core and the opcode and funct values known to decode
//==========================================================================
`ifndef PIPECTRL_SETTINGS_SVH
`define PIPECTRL_SETTINGS_SVH

// Core widths
`define PC_DATA_WIDTH      32
`define PC_ADDR_WIDTH      32
`define PC_REG_ADDR_WIDTH  5
`define PC_OP_WIDTH        6
`define PC_FUNCT_WIDTH     6

// Primary opcodes
`define PC_OP_RTYPE  6'h00
`define PC_OP_J      6'h02
`define PC_OP_BEQ    6'h04
`define PC_OP_BNE    6'h05
`define PC_OP_ADDI   6'h08
`define PC_OP_ORI    6'h0D
`define PC_OP_LW     6'h23
`define PC_OP_SW     6'h2B

// R-type funct values handled by the ALU
`define PC_FUNCT_SLL   6'h00
`define PC_FUNCT_SRL   6'h02
`define PC_FUNCT_ADD   6'h20
`define PC_FUNCT_ADDU  6'h21
`define PC_FUNCT_SUB   6'h22
`define PC_FUNCT_AND   6'h24
`define PC_FUNCT_OR    6'h25
`define PC_FUNCT_SLT   6'h2A

`endif

/* pipeCtrl_pkg.sv */
//==========================================================================
// Pipeline control types
// Instruction word views, register-use info, stage destinations and
// per-stage stall and smash controls
//==========================================================================
`include "pipeCtrl_settings.svh"

package pipeCtrl_pkg;

	// R-type view of the instruction word
	typedef struct packed {
		logic [`PC_OP_WIDTH-1:0]       opcode;
		logic [`PC_REG_ADDR_WIDTH-1:0] rs;
		logic [`PC_REG_ADDR_WIDTH-1:0] rt;
		logic [`PC_REG_ADDR_WIDTH-1:0] rd;
		logic [`PC_REG_ADDR_WIDTH-1:0] shamt;
		logic [`PC_FUNCT_WIDTH-1:0]    funct;
	} rTypeFields_t;

	// I-type view, immediate fills what is left of the word
	typedef struct packed {
		logic [`PC_OP_WIDTH-1:0]       opcode;
		logic [`PC_REG_ADDR_WIDTH-1:0] rs;
		logic [`PC_REG_ADDR_WIDTH-1:0] rt;
		logic [`PC_DATA_WIDTH-`PC_OP_WIDTH-2*`PC_REG_ADDR_WIDTH-1:0] imm;
	} iTypeFields_t;

	// One instruction word, two decodings
	typedef union packed {
		rTypeFields_t rType;
		iTypeFields_t iType;
	} instrWord_u;

	// Registers read by the instruction in decode
	typedef struct packed {
		logic                          usesRs;
		logic [`PC_REG_ADDR_WIDTH-1:0] rsAddr;
		logic                          usesRt;
		logic [`PC_REG_ADDR_WIDTH-1:0] rtAddr;
		logic                          branchInstr;  // Branch or jump sits in decode
	} decInfo_t;

	// Destination of one stage, all zero is a bubble
	typedef struct packed {
		logic                          writesBack;
		logic                          usesMem;
		logic [`PC_REG_ADDR_WIDTH-1:0] writeAddr;
	} stageWrite_t;

	typedef struct packed {
		logic stall;  // Stage holds its contents
		logic smash;  // Stage output becomes a bubble
	} stageCtrl_t;

	// Controls for the whole pipe, IF in the top bits
	typedef struct packed {
		stageCtrl_t ifStg;
		stageCtrl_t decStg;
		stageCtrl_t exStg;
		stageCtrl_t memStg;
		stageCtrl_t wbStg;
	} pipeCtrl_t;

	typedef struct packed {
		logic                      taken;
		logic [`PC_ADDR_WIDTH-1:0] target;
	} branchReq_t;

endpackage

/* instrDecoder.sv */
`timescale 1ns/1ps
//==========================================================================
// Instruction decoder
// Turns the decode-stage instruction into register use, destination,
// memory use and branch flags, purely combinational
//==========================================================================
`include "pipeCtrl_settings.svh"

module instrDecoder
(
	input  logic                      i_DecValid,  // Decode holds a live instruction
	input  pipeCtrl_pkg::instrWord_u  i_Instr,
	output pipeCtrl_pkg::decInfo_t    o_DecInfo,
	output pipeCtrl_pkg::stageWrite_t o_DecWrite
);
	logic                          knownFunct;  // R-type funct the ALU handles
	logic                          writes;
	logic                          usesMem;
	logic [`PC_REG_ADDR_WIDTH-1:0] destAddr;
	pipeCtrl_pkg::decInfo_t        info;

	// R-type funct check through the R view
	always_comb
	begin
		case (i_Instr.rType.funct)
			`PC_FUNCT_SLL, `PC_FUNCT_SRL, `PC_FUNCT_ADD, `PC_FUNCT_ADDU,
			`PC_FUNCT_SUB, `PC_FUNCT_AND, `PC_FUNCT_OR, `PC_FUNCT_SLT:
				knownFunct = 1'b1;
			default:
				knownFunct = 1'b0;
		endcase
	end

	always_comb
	begin
		info     = '0;
		writes   = 1'b0;
		usesMem  = 1'b0;
		destAddr = '0;
		if (i_DecValid)
		begin
			case (i_Instr.iType.opcode)
				`PC_OP_RTYPE:
				begin
					if (knownFunct)
					begin
						info.usesRs = 1'b1;
						info.rsAddr = i_Instr.rType.rs;
						info.usesRt = 1'b1;
						info.rtAddr = i_Instr.rType.rt;
						writes      = 1'b1;
						destAddr    = i_Instr.rType.rd;  // R-type writes rd
					end
				end
				`PC_OP_LW:
				begin
					info.usesRs = 1'b1;       // Base register
					info.rsAddr = i_Instr.iType.rs;
					writes      = 1'b1;
					usesMem     = 1'b1;
					destAddr    = i_Instr.iType.rt;
				end
				`PC_OP_SW:
				begin
					info.usesRs = 1'b1;
					info.rsAddr = i_Instr.iType.rs;
					info.usesRt = 1'b1;       // Store data
					info.rtAddr = i_Instr.iType.rt;
					usesMem     = 1'b1;
				end
				`PC_OP_BEQ, `PC_OP_BNE:
				begin
					info.usesRs      = 1'b1;
					info.rsAddr      = i_Instr.iType.rs;
					info.usesRt      = 1'b1;
					info.rtAddr      = i_Instr.iType.rt;
					info.branchInstr = 1'b1;
				end
				`PC_OP_J:
					info.branchInstr = 1'b1;  // Target comes from the word, no registers
				`PC_OP_ADDI, `PC_OP_ORI:
				begin
					info.usesRs = 1'b1;
					info.rsAddr = i_Instr.iType.rs;
					writes      = 1'b1;
					destAddr    = i_Instr.iType.rt;
				end
				default:
					destAddr = '0;            // Unknown opcode stays a bubble
			endcase
		end
	end

	assign o_DecInfo = info;

	// Register zero is never a real destination
	assign o_DecWrite.writesBack = writes && (destAddr != '0);
	assign o_DecWrite.usesMem    = usesMem;
	assign o_DecWrite.writeAddr  = destAddr;

endmodule

/* stageTracker.sv */
`timescale 1ns/1ps
//==========================================================================
// Stage tracker
// Carries destination info of the instructions in EX, MEM and WB,
// advancing, holding or taking bubbles under the hazard controls
//==========================================================================

module stageTracker
(
	input  logic                      i_Clk,
	input  logic                      i_Reset_n,
	input  pipeCtrl_pkg::stageWrite_t i_DecWrite,  // Destination of the instruction in DEC
	input  pipeCtrl_pkg::pipeCtrl_t   i_Ctrl,
	output pipeCtrl_pkg::stageWrite_t o_ExWrite,
	output pipeCtrl_pkg::stageWrite_t o_MemWrite,
	output pipeCtrl_pkg::stageWrite_t o_WbWrite
);
	localparam int NUM_STAGES = 3;  // EX, MEM, WB

	pipeCtrl_pkg::stageWrite_t stageReg [NUM_STAGES];  // 0 is EX, 2 is WB
	pipeCtrl_pkg::stageWrite_t stageIn  [NUM_STAGES];  // Value from the stage upstream
	logic [NUM_STAGES-1:0]     holdStage;              // Own stall
	logic [NUM_STAGES-1:0]     bubbleIn;               // Upstream smash

	//======================================================================
	// Per-stage inputs
	//======================================================================
	always_comb
	begin
		stageIn[0] = i_DecWrite;
		stageIn[1] = stageReg[0];
		stageIn[2] = stageReg[1];

		holdStage[0] = i_Ctrl.exStg.stall;
		holdStage[1] = i_Ctrl.memStg.stall;
		holdStage[2] = i_Ctrl.wbStg.stall;

		// A smash in a stage sends a bubble into the next one
		bubbleIn[0] = i_Ctrl.decStg.smash;
		bubbleIn[1] = i_Ctrl.exStg.smash;
		bubbleIn[2] = i_Ctrl.memStg.smash;
	end

	//======================================================================
	// Stage registers
	//======================================================================
	always_ff @(posedge i_Clk or negedge i_Reset_n)
	begin
		if (!i_Reset_n)
		begin
			for (int s = 0; s < NUM_STAGES; s++)
			begin
				stageReg[s] <= '0;  // Empty pipe after reset
			end
		end
		else
		begin
			for (int s = 0; s < NUM_STAGES; s++)
			begin
				if (holdStage[s])
				begin
					stageReg[s] <= stageReg[s];  // Stalled stage keeps its instruction
				end
				else if (bubbleIn[s])
				begin
					stageReg[s] <= '0;
				end
				else
				begin
					stageReg[s] <= stageIn[s];
				end
			end
		end
	end

	assign o_ExWrite  = stageReg[0];
	assign o_MemWrite = stageReg[1];
	assign o_WbWrite  = stageReg[2];

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps
//==========================================================================
// Hazard unit
// Stall and smash for every stage, branch redirect to fetch, and the
// registers that hold a branch taken while fetch is busy
//==========================================================================

module hazardUnit
(
	input  logic                      i_Clk,
	input  logic                      i_Reset_n,
	input  logic                      i_FlashLoaderDone,  // Program image is loaded
	input  logic                      i_Done,             // Program has finished
	input  pipeCtrl_pkg::decInfo_t    i_DecInfo,
	input  logic                      i_IfDone,           // Fetch output is valid
	input  pipeCtrl_pkg::stageWrite_t i_ExWrite,
	input  pipeCtrl_pkg::stageWrite_t i_MemWrite,
	input  pipeCtrl_pkg::stageWrite_t i_WbWrite,
	input  pipeCtrl_pkg::branchReq_t  i_ExBranch,         // Taken branch from execute
	input  logic                      i_MemDone,          // Data memory op finished
	output pipeCtrl_pkg::pipeCtrl_t   o_Ctrl,
	output pipeCtrl_pkg::branchReq_t  o_IfBranch
);
	logic                     executing;
	logic                     loadUse;     // Load in EX feeds decode
	logic                     branchWait;  // Branch in DEC waits for the delay slot
	logic                     heldSmash;   // Smash the fetch that was busy at branch time
	pipeCtrl_pkg::branchReq_t heldBranch;  // Branch waiting for the IF stall to drop
	pipeCtrl_pkg::pipeCtrl_t  ctrl;

	// True when decode reads the register a stage writes
	function automatic logic readsDest(input pipeCtrl_pkg::decInfo_t info,
		input pipeCtrl_pkg::stageWrite_t wr);
		logic rsHit;
		logic rtHit;
		rsHit = info.usesRs && (info.rsAddr == wr.writeAddr);
		rtHit = info.usesRt && (info.rtAddr == wr.writeAddr);
		return wr.writesBack && (rsHit || rtHit);
	endfunction

	assign executing  = i_FlashLoaderDone && !i_Done;
	assign loadUse    = readsDest(i_DecInfo, i_ExWrite) && i_ExWrite.usesMem;
	assign branchWait = i_DecInfo.branchInstr && !i_IfDone;

	//======================================================================
	// Stall and smash, chained backwards from WB
	//======================================================================
	always_comb
	begin
		ctrl = '1;  // Idle or finished, everything stalls and smashes
		if (executing)
		begin
			// WB never stalls or smashes while running
			ctrl.wbStg = '0;

			// Waiting on data memory, do not let MEM write back
			ctrl.memStg.smash = !i_MemDone;
			ctrl.memStg.stall = !i_MemDone || ctrl.wbStg.stall;

			ctrl.exStg.stall = ctrl.memStg.stall;
			ctrl.exStg.smash = 1'b0;

			// Load-use or branch without delay slot keeps DEC out of EX
			ctrl.decStg.smash = loadUse || branchWait;
			ctrl.decStg.stall = ctrl.decStg.smash || ctrl.exStg.stall;

			ctrl.ifStg.stall = ctrl.decStg.stall || !i_IfDone;
			ctrl.ifStg.smash = i_ExBranch.taken || !i_IfDone || heldSmash;
		end
	end

	assign o_Ctrl = ctrl;

	//======================================================================
	// Held branch handling
	//======================================================================

	// Branch while IMEM is busy, smash the fetch once it lands
	always_ff @(posedge i_Clk or negedge i_Reset_n)
	begin
		if (!i_Reset_n)
		begin
			heldSmash <= 1'b0;
		end
		else if (i_ExBranch.taken && !i_IfDone)
		begin
			heldSmash <= 1'b1;
		end
		else if (i_IfDone && heldSmash)
		begin
			heldSmash <= 1'b0;  // Smash applied this cycle
		end
	end

	// Branch during an IF stall is kept until the stall drops
	always_ff @(posedge i_Clk or negedge i_Reset_n)
	begin
		if (!i_Reset_n)
		begin
			heldBranch <= '0;
		end
		else if (ctrl.ifStg.stall && i_ExBranch.taken)
		begin
			heldBranch <= i_ExBranch;
		end
		else if (heldBranch.taken && !ctrl.ifStg.stall)
		begin
			heldBranch.taken <= 1'b0;  // Delivered in this cycle
		end
	end

	// Live branch wins over the held one
	assign o_IfBranch.taken  = i_ExBranch.taken || heldBranch.taken;
	assign o_IfBranch.target = i_ExBranch.taken ? i_ExBranch.target : heldBranch.target;

endmodule

/* pipeCtrlTop.sv */
`timescale 1ns/1ps
//==========================================================================
// Pipeline control top level
// Decoder, stage tracker and hazard unit around the core status signals
//==========================================================================

module pipeCtrlTop
(
	input  logic                     i_Clk,
	input  logic                     i_Reset_n,
	input  logic                     i_FlashLoaderDone,
	input  logic                     i_Done,
	input  logic                     i_DecValid,
	input  pipeCtrl_pkg::instrWord_u i_DecInstr,  // Word held in decode
	input  logic                     i_IfDone,
	input  logic                     i_MemDone,
	input  pipeCtrl_pkg::branchReq_t i_ExBranch,
	output pipeCtrl_pkg::pipeCtrl_t  o_Ctrl,
	output pipeCtrl_pkg::branchReq_t o_IfBranch
);
	pipeCtrl_pkg::decInfo_t    decInfo;
	pipeCtrl_pkg::stageWrite_t decWrite;
	pipeCtrl_pkg::stageWrite_t exWrite;
	pipeCtrl_pkg::stageWrite_t memWrite;
	pipeCtrl_pkg::stageWrite_t wbWrite;
	pipeCtrl_pkg::pipeCtrl_t   ctrl;  // Also steers the tracker

	instrDecoder decoder_i
	(
		.i_DecValid (i_DecValid),
		.i_Instr    (i_DecInstr),
		.o_DecInfo  (decInfo),
		.o_DecWrite (decWrite)
	);

	stageTracker tracker_i
	(
		.i_Clk      (i_Clk),
		.i_Reset_n  (i_Reset_n),
		.i_DecWrite (decWrite),
		.i_Ctrl     (ctrl),
		.o_ExWrite  (exWrite),
		.o_MemWrite (memWrite),
		.o_WbWrite  (wbWrite)
	);

	hazardUnit hazard_i
	(
		.i_Clk             (i_Clk),
		.i_Reset_n         (i_Reset_n),
		.i_FlashLoaderDone (i_FlashLoaderDone),
		.i_Done            (i_Done),
		.i_DecInfo         (decInfo),
		.i_IfDone          (i_IfDone),
		.i_ExWrite         (exWrite),
		.i_MemWrite        (memWrite),
		.i_WbWrite         (wbWrite),
		.i_ExBranch        (i_ExBranch),
		.i_MemDone         (i_MemDone),
		.o_Ctrl            (ctrl),
		.o_IfBranch        (o_IfBranch)
	);

	assign o_Ctrl = ctrl;

endmodule

/* tb_pipeCtrl.sv */
`timescale 1ns/1ps
//==========================================================================
// Pipeline control testbench
// Directed tests of stall, smash and branch redirect on the top level
//==========================================================================
`include "pipeCtrl_settings.svh"

module tb_pipeCtrl;

	localparam int HALF_PERIOD     = 20;
	localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
	localparam int RESET_CYCLES    = 5;
	localparam int MEM_WAIT_CYCLES = 3;
	// Cycles of each test in run order
	localparam int TEST_CYCLES  = 4 + 6 + (MEM_WAIT_CYCLES + 1) + 6 + 5;
	localparam int MARGIN       = 20;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD;

	logic                     i_Clk;
	logic                     i_Reset_n;
	logic                     i_FlashLoaderDone;
	logic                     i_Done;
	logic                     i_DecValid;
	pipeCtrl_pkg::instrWord_u i_DecInstr;
	logic                     i_IfDone;
	logic                     i_MemDone;
	pipeCtrl_pkg::branchReq_t i_ExBranch;
	pipeCtrl_pkg::pipeCtrl_t  o_Ctrl;
	pipeCtrl_pkg::branchReq_t o_IfBranch;

	integer seed;
	int     checkCount;
	int     ctrlErrors;
	int     branchErrors;

	pipeCtrlTop dut_i
	(
		.i_Clk             (i_Clk),
		.i_Reset_n         (i_Reset_n),
		.i_FlashLoaderDone (i_FlashLoaderDone),
		.i_Done            (i_Done),
		.i_DecValid        (i_DecValid),
		.i_DecInstr        (i_DecInstr),
		.i_IfDone          (i_IfDone),
		.i_MemDone         (i_MemDone),
		.i_ExBranch        (i_ExBranch),
		.o_Ctrl            (o_Ctrl),
		.o_IfBranch        (o_IfBranch)
	);

	always #HALF_PERIOD i_Clk = ~i_Clk;

	//======================================================================
	// Instruction builders and random values
	//======================================================================
	function automatic pipeCtrl_pkg::instrWord_u rTypeWord(
		input logic [`PC_REG_ADDR_WIDTH-1:0] rs,
		input logic [`PC_REG_ADDR_WIDTH-1:0] rt,
		input logic [`PC_REG_ADDR_WIDTH-1:0] rd,
		input logic [`PC_FUNCT_WIDTH-1:0]    funct);
		pipeCtrl_pkg::instrWord_u w;
		w                = '0;
		w.rType.opcode   = `PC_OP_RTYPE;
		w.rType.rs       = rs;
		w.rType.rt       = rt;
		w.rType.rd       = rd;
		w.rType.funct    = funct;
		return w;
	endfunction

	function automatic pipeCtrl_pkg::instrWord_u iTypeWord(
		input logic [`PC_OP_WIDTH-1:0]       op,
		input logic [`PC_REG_ADDR_WIDTH-1:0] rs,
		input logic [`PC_REG_ADDR_WIDTH-1:0] rt,
		input logic [`PC_DATA_WIDTH-`PC_OP_WIDTH-2*`PC_REG_ADDR_WIDTH-1:0] imm);
		pipeCtrl_pkg::instrWord_u w;
		w.iType.opcode = op;
		w.iType.rs     = rs;
		w.iType.rt     = rt;
		w.iType.imm    = imm;
		return w;
	endfunction

	// Nonzero register number, r0 is never a destination
	function automatic logic [`PC_REG_ADDR_WIDTH-1:0] randomReg();
		integer                        v;
		logic [`PC_REG_ADDR_WIDTH-1:0] r;
		v = $random(seed);
		r = v[`PC_REG_ADDR_WIDTH-1:0];
		if (r == '0)
			r[0] = 1'b1;
		return r;
	endfunction

	function automatic logic [`PC_ADDR_WIDTH-1:0] randomTarget();
		integer                    v;
		logic [`PC_ADDR_WIDTH-1:0] t;
		v      = $random(seed);
		t      = v;
		t[1:0] = 2'b00;  // Word aligned
		return t;
	endfunction

	//======================================================================
	// Compare tasks
	//======================================================================
	task automatic checkCtrl(input pipeCtrl_pkg::pipeCtrl_t expCtrl, input string what);
		checkCount++;
		if (o_Ctrl !== expCtrl)
		begin
			ctrlErrors++;
			$display("FAILED at %0d ns: %s, IF..WB stall/smash expected %b got %b",
				$time, what, expCtrl, o_Ctrl);
		end
	endtask

	// Target only matters when a redirect is expected
	task automatic checkBranch(input pipeCtrl_pkg::branchReq_t expBranch, input string what);
		logic mismatch;
		checkCount++;
		mismatch = (o_IfBranch.taken !== expBranch.taken) ||
			(expBranch.taken && (o_IfBranch.target !== expBranch.target));
		if (mismatch)
		begin
			branchErrors++;
			$display("FAILED at %0d ns: %s, branch expected %b/%h got %b/%h", $time, what,
				expBranch.taken, expBranch.target, o_IfBranch.taken, o_IfBranch.target);
		end
	endtask

	//======================================================================
	// Tests
	//======================================================================
	task automatic notExecutingTest();
		pipeCtrl_pkg::pipeCtrl_t allSet;
		allSet = '1;
		@(negedge i_Clk);
		checkCtrl(allSet, "loader not done");
		checkBranch('0, "loader not done");
		@(posedge i_Clk);
		i_FlashLoaderDone <= 1'b1;
		@(negedge i_Clk);
		checkCtrl('0, "running and idle");
		@(posedge i_Clk);
		i_Done <= 1'b1;  // Program end freezes the pipe
		@(negedge i_Clk);
		checkCtrl(allSet, "program done");
		@(posedge i_Clk);
		i_Done <= 1'b0;
		@(negedge i_Clk);
		checkCtrl('0, "running again");
	endtask

	task automatic loadUseTest();
		logic [`PC_REG_ADDR_WIDTH-1:0] r;
		pipeCtrl_pkg::pipeCtrl_t       expCtrl;
		r                     = randomReg();
		expCtrl               = '0;
		expCtrl.decStg        = '{1'b1, 1'b1};
		expCtrl.ifStg.stall   = 1'b1;
		@(posedge i_Clk);
		i_DecValid <= 1'b1;
		i_DecInstr <= iTypeWord(`PC_OP_LW, '0, r, 16'h0010);
		@(negedge i_Clk);
		checkCtrl('0, "LW in decode");
		@(posedge i_Clk);
		i_DecInstr <= rTypeWord(r, '0, r, `PC_FUNCT_ADD);  // Reads the load result
		@(negedge i_Clk);
		checkCtrl(expCtrl, "load-use stall");
		@(posedge i_Clk);
		@(negedge i_Clk);
		checkCtrl('0, "load-use released");
		// Same pair with an ALU producer
		@(posedge i_Clk);
		i_DecInstr <= iTypeWord(`PC_OP_ADDI, '0, r, 16'h0001);
		@(negedge i_Clk);
		checkCtrl('0, "ADDI in decode");
		@(posedge i_Clk);
		i_DecInstr <= rTypeWord(r, '0, r, `PC_FUNCT_ADD);
		@(negedge i_Clk);
		checkCtrl('0, "ADDI producer, no stall");
		@(posedge i_Clk);
		i_DecValid <= 1'b0;
		@(negedge i_Clk);
		checkCtrl('0, "decode idle");
	endtask

	task automatic memWaitTest();
		pipeCtrl_pkg::pipeCtrl_t expCtrl;
		expCtrl        = '0;
		expCtrl.memStg = '{1'b1, 1'b1};
		expCtrl.exStg  = '{1'b1, 1'b0};  // Chained back from MEM
		expCtrl.decStg = '{1'b1, 1'b0};
		expCtrl.ifStg  = '{1'b1, 1'b0};
		for (int i = 0; i < MEM_WAIT_CYCLES; i++)
		begin
			@(posedge i_Clk);
			i_MemDone <= 1'b0;
			@(negedge i_Clk);
			checkCtrl(expCtrl, "memory wait");
		end
		@(posedge i_Clk);
		i_MemDone <= 1'b1;
		@(negedge i_Clk);
		checkCtrl('0, "memory done");
	endtask

	task automatic branchRedirectTest();
		pipeCtrl_pkg::branchReq_t liveBr;
		pipeCtrl_pkg::branchReq_t heldBr;
		pipeCtrl_pkg::pipeCtrl_t  expCtrl;
		liveBr  = '{1'b1, randomTarget()};
		heldBr  = '{1'b1, randomTarget()};
		expCtrl = '0;
		@(posedge i_Clk);
		i_ExBranch <= liveBr;
		@(negedge i_Clk);
		expCtrl.ifStg = '{1'b0, 1'b1};
		checkBranch(liveBr, "live branch");
		checkCtrl(expCtrl, "live branch smashes IF");
		@(posedge i_Clk);
		i_ExBranch <= '0;
		@(negedge i_Clk);
		checkBranch('0, "after live branch");
		checkCtrl('0, "after live branch");
		// Branch lands while fetch is busy
		@(posedge i_Clk);
		i_IfDone   <= 1'b0;
		i_ExBranch <= heldBr;
		@(negedge i_Clk);
		expCtrl.ifStg = '{1'b1, 1'b1};
		checkBranch(heldBr, "branch during IF stall");
		checkCtrl(expCtrl, "branch during IF stall");
		@(posedge i_Clk);
		i_ExBranch <= '0;
		@(negedge i_Clk);
		checkCtrl(expCtrl, "IF still busy");
		@(posedge i_Clk);
		i_IfDone <= 1'b1;
		@(negedge i_Clk);
		expCtrl.ifStg = '{1'b0, 1'b1};  // Held smash kills the late fetch
		checkBranch(heldBr, "held branch delivered");
		checkCtrl(expCtrl, "held branch delivered");
		@(posedge i_Clk);
		@(negedge i_Clk);
		checkBranch('0, "held branch cleared");
		checkCtrl('0, "held branch cleared");
	endtask

	task automatic branchInDecodeTest();
		logic [`PC_REG_ADDR_WIDTH-1:0] r;
		pipeCtrl_pkg::pipeCtrl_t       expCtrl;
		r              = randomReg();
		expCtrl        = '0;
		expCtrl.decStg = '{1'b1, 1'b1};
		expCtrl.ifStg  = '{1'b1, 1'b1};
		@(posedge i_Clk);
		i_DecValid <= 1'b1;
		i_DecInstr <= iTypeWord(`PC_OP_BEQ, r, '0, 16'h0004);
		i_IfDone   <= 1'b0;
		@(negedge i_Clk);
		checkCtrl(expCtrl, "branch waits for fetch");
		@(posedge i_Clk);
		i_IfDone <= 1'b1;
		@(negedge i_Clk);
		checkCtrl('0, "branch with fetch done");
		// J ignores its rs field
		@(posedge i_Clk);
		i_DecInstr <= iTypeWord(`PC_OP_LW, '0, r, 16'h0020);
		@(negedge i_Clk);
		checkCtrl('0, "LW ahead of J");
		@(posedge i_Clk);
		i_DecInstr <= iTypeWord(`PC_OP_J, r, '0, '0);
		@(negedge i_Clk);
		checkCtrl('0, "J after load, no stall");
		@(posedge i_Clk);
		i_DecValid <= 1'b0;
		@(negedge i_Clk);
		checkCtrl('0, "decode idle");
	endtask

	//======================================================================
	// Sequence and watchdog
	//======================================================================
	initial
	begin
		seed              = 74913;
		checkCount        = 0;
		ctrlErrors        = 0;
		branchErrors      = 0;
		i_Clk             = 1'b0;
		i_Reset_n         = 1'b0;
		i_FlashLoaderDone = 1'b0;
		i_Done            = 1'b0;
		i_DecValid        = 1'b0;
		i_DecInstr        = '0;
		i_IfDone          = 1'b1;
		i_MemDone         = 1'b1;
		i_ExBranch        = '0;
		repeat (RESET_CYCLES) @(posedge i_Clk);
		i_Reset_n <= 1'b1;

		notExecutingTest();
		loadUseTest();
		memWaitTest();
		branchRedirectTest();
		branchInDecodeTest();

		$display("Checks: %0d, ctrl errors: %0d, branch errors: %0d",
			checkCount, ctrlErrors, branchErrors);
		if (ctrlErrors + branchErrors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Errors found");
		$finish;
	end

endmodule

/* files.f */
+incdir+.
pipeCtrl_pkg.sv
instrDecoder.sv
stageTracker.sv
hazardUnit.sv
pipeCtrlTop.sv
tb_pipeCtrl.sv

/* Makefile */
# Verilator build and run for the pipeline control testbench

VERILATOR ?= verilator
TOP       ?= tb_pipeCtrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) pipeCtrl_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
